/* compile.f */
logic/irq_pkg.sv
logic/int_sampler.sv
logic/interval_timer.sv
logic/int_controller.sv
logic/irq_timer_top.sv
dv/tb_clock_gen.sv
dv/irq_timer_properties.sv
dv/irq_timer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the interrupt and timer testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module irq_timer_tb \
  -f compile.f \
  -Mdir obj_dir

./obj_dir/Virq_timer_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

/* dv/irq_timer_tb.sv */
//////////////////////////////////////////////////
// Table-driven testbench for the interrupt and
// timer subsystem
//////////////////////////////////////////////////

`timescale 1ns/1ps

module irq_timer_tb
  import irq_pkg::*;
;

  localparam int SAMPLE_DIV    = 12;
  localparam int PRESCALE_BITS = 3;
  localparam int SEED          = 91879;
  // Long enough for any edge to pass the filter
  localparam int HOLD          = 5 * SAMPLE_DIV;

  typedef enum logic [3:0] {
    OP_IDLE, OP_INT0, OP_INT1, OP_INT2, OP_WR_MK, OP_WR_TM0, OP_WR_TM1, OP_STM,
    OP_EI, OP_DI, OP_FETCH, OP_TAKE, OP_SKIT, OP_GLITCH, OP_UF_PERIOD
  } op_e;

  typedef enum logic [2:0] {
    CHK_NONE, CHK_PEND, CHK_VEC, CHK_REQ, CHK_HIT, CHK_PERIOD
  } chk_e;

  typedef struct packed {
    op_e         op;
    logic [7:0]  arg;
    logic [15:0] cycles;
    chk_e        chk;
    logic [15:0] exp;
  } step_s;

  logic       CLK;
  logic       rst_n;
  logic       int0;
  logic       int1;
  logic       int2;
  logic       stm;
  logic       ei;
  logic       di;
  logic       fetch_start;
  logic       irq_take;
  logic       skit;
  int_idx_e   skit_sel;
  spr_wr_s    spr_wr;
  int_flags_t pending;
  logic       irq_req;
  vector_t    irq_vector;
  logic       skit_hit;
  logic       timer_uf;

  step_s steps[$];
  string names[$];
  int    fail_count = 0;
  int    watchdog_cycles = 0;

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clk (.CLK(CLK), .rst_n(rst_n));

  irq_timer_top #(
    .SAMPLE_DIV    (SAMPLE_DIV),
    .PRESCALE_BITS (PRESCALE_BITS)
  ) dut0 (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .int0        (int0),
    .int1        (int1),
    .int2        (int2),
    .stm         (stm),
    .ei          (ei),
    .di          (di),
    .fetch_start (fetch_start),
    .irq_take    (irq_take),
    .skit        (skit),
    .skit_sel    (skit_sel),
    .spr_wr      (spr_wr),
    .pending     (pending),
    .irq_req     (irq_req),
    .irq_vector  (irq_vector),
    .skit_hit    (skit_hit),
    .timer_uf    (timer_uf)
  );

  //////////////////////////////////////////////////
  // Expected value helpers

  function automatic int flag_bit(input int_idx_e idx);
    return 1 << int'(idx);
  endfunction

  // Reload value plus one, times the prescaler length
  function automatic int uf_period(input int tm);
    return (1 << PRESCALE_BITS) * (tm + 1);
  endfunction

  function automatic spr_wr_s bus_write(input spr_sel_e sel, input spr_data_t data);
    spr_wr_s w;
    w.en   = 1'b1;
    w.sel  = sel;
    w.data = data;
    return w;
  endfunction

  function automatic bit is_strobe(input op_e op);
    return op inside {OP_WR_MK, OP_WR_TM0, OP_WR_TM1, OP_STM, OP_EI, OP_DI,
                      OP_FETCH, OP_TAKE, OP_SKIT};
  endfunction

  task automatic report_mismatch(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    fail_count++;
    $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
    $display("Result: FAILED");
    $fatal(1, "Mismatch in step %s", name);
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  task automatic drive_op(input step_s s);
    case (s.op)
      OP_INT0:   int0 <= s.arg[0];
      OP_INT1:   int1 <= s.arg[0];
      OP_INT2:   int2 <= s.arg[0];
      OP_WR_MK:  spr_wr <= bus_write(SPR_MK, s.arg);
      OP_WR_TM0: spr_wr <= bus_write(SPR_TM0, s.arg);
      OP_WR_TM1: spr_wr <= bus_write(SPR_TM1, s.arg);
      OP_STM:    stm <= 1'b1;
      OP_EI:     ei <= 1'b1;
      OP_DI:     di <= 1'b1;
      OP_FETCH:  fetch_start <= 1'b1;
      OP_TAKE:   irq_take <= 1'b1;
      OP_SKIT: begin
        skit     <= 1'b1;
        skit_sel <= int_idx_e'(s.arg[2:0]);
      end
      default: ;
    endcase
  endtask

  task automatic release_strobes();
    spr_wr      <= '0;
    stm         <= 1'b0;
    ei          <= 1'b0;
    di          <= 1'b0;
    fetch_start <= 1'b0;
    irq_take    <= 1'b0;
    skit        <= 1'b0;
  endtask

  // High pulses under one sample period, each followed by a low gap of
  // at least one period, so no two consecutive samples can read high
  task automatic send_glitches(input int count);
    int unsigned width;
    int unsigned gap;
    logic [1:0]  lines;
    for (int i = 0; i < count; i++) begin
      width = $urandom_range(SAMPLE_DIV - 1, 1);
      gap   = $urandom_range(2 * SAMPLE_DIV - 1, SAMPLE_DIV);
      lines = 2'($urandom_range(3, 1));
      @(posedge CLK);
      int1 <= lines[0];
      int2 <= lines[1];
      repeat (width) @(posedge CLK);
      int1 <= 1'b0;
      int2 <= 1'b0;
      repeat (gap - 1) @(posedge CLK);
    end
  endtask

  task automatic wait_uf(input int limit, output int cycles);
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
      if (cycles > limit) begin
        fail_count++;
        $display("ERROR: no timer underflow pulse within %0d cycles", limit);
        $display("Result: FAILED");
        $fatal(1, "Timer underflow timeout");
      end
    end while (!timer_uf);
  endtask

  // First wait aligns to a pulse, the second measures the gap
  task automatic measure_uf_period(input int limit, output int period);
    int align;
    wait_uf(limit, align);
    wait_uf(limit, period);
  endtask

  //////////////////////////////////////////////////
  // Step execution

  task automatic run_step(input string name, input step_s s);
    int          period;
    logic [15:0] actual;
    period = 0;
    actual = '0;
    case (s.op)
      OP_GLITCH:    send_glitches(int'(s.arg));
      OP_UF_PERIOD: measure_uf_period(2 * int'(s.exp) + 8, period);
      default: begin
        @(posedge CLK);
        drive_op(s);
        if (is_strobe(s.op)) begin
          // skit_hit is only valid while skit is high
          @(negedge CLK);
          if (s.chk == CHK_HIT) begin
            assert (skit_hit == s.exp[0])
              else report_mismatch(name, s.exp, {15'd0, skit_hit});
          end
          @(posedge CLK);
          release_strobes();
        end
      end
    endcase
    repeat (s.cycles) @(posedge CLK);
    @(negedge CLK);
    if (s.chk != CHK_NONE && s.chk != CHK_HIT) begin
      case (s.chk)
        CHK_PEND: actual = 16'(pending);
        CHK_VEC:  actual = 16'(irq_vector);
        CHK_REQ:  actual = 16'(irq_req);
        default:  actual = 16'(period);
      endcase
      assert (actual == s.exp) else report_mismatch(name, s.exp, actual);
    end
  endtask

  task automatic add_step(input string name, input op_e op, input int arg,
                          input int cycles, input chk_e chk, input int exp);
    step_s s;
    s.op     = op;
    s.arg    = 8'(arg);
    s.cycles = 16'(cycles);
    s.chk    = chk;
    s.exp    = 16'(exp);
    steps.push_back(s);
    names.push_back(name);
  endtask

  //////////////////////////////////////////////////
  // Step table

  task automatic build_table();
    add_step("reset_pending", OP_IDLE, 0, 0, CHK_PEND, 0);
    add_step("reset_req", OP_IDLE, 0, 0, CHK_REQ, 0);
    add_step("reset_vector", OP_IDLE, 0, 0, CHK_VEC, int'(VEC_NONE));
    add_step("int0_high", OP_INT0, 1, 1, CHK_PEND, flag_bit(INT0));
    add_step("int0_low", OP_INT0, 0, 1, CHK_PEND, 0);
    // Edge filters
    add_step("int1_high", OP_INT1, 1, HOLD, CHK_PEND, flag_bit(INT1));
    add_step("int1_low", OP_INT1, 0, HOLD, CHK_PEND, flag_bit(INT1));
    add_step("int1_skit", OP_SKIT, int'(INT1), 0, CHK_HIT, 1);
    add_step("int1_cleared", OP_IDLE, 0, 0, CHK_PEND, 0);
    add_step("int2_high", OP_INT2, 1, HOLD, CHK_PEND, flag_bit(INT2));
    add_step("int2_low", OP_INT2, 0, HOLD, CHK_PEND, flag_bit(INT2));
    add_step("int2_skit", OP_SKIT, int'(INT2), 0, CHK_HIT, 1);
    add_step("glitches", OP_GLITCH, 20, HOLD, CHK_PEND, 0);
    // Inverted INT2 polarity with MK bit 5 clear
    add_step("mk5_clear", OP_WR_MK, 'hdf, HOLD, CHK_PEND, flag_bit(INT2));
    add_step("mk5_skit", OP_SKIT, int'(INT2), 0, CHK_HIT, 1);
    add_step("int2_inv_high", OP_INT2, 1, HOLD, CHK_PEND, 0);
    add_step("int2_inv_low", OP_INT2, 0, HOLD, CHK_PEND, flag_bit(INT2));
    add_step("mk5_skit_again", OP_SKIT, int'(INT2), 0, CHK_HIT, 1);
    add_step("mk5_restore", OP_WR_MK, 'hff, HOLD, CHK_PEND, 0);
    // Interval timer
    add_step("tm0_write", OP_WR_TM0, 3, 0, CHK_NONE, 0);
    add_step("tm1_write", OP_WR_TM1, 0, 0, CHK_NONE, 0);
    add_step("timer_reload", OP_STM, 0, 0, CHK_NONE, 0);
    add_step("uf_period", OP_UF_PERIOD, 0, 0, CHK_PERIOD, uf_period(3));
    add_step("intt_set", OP_IDLE, 0, 0, CHK_PEND, flag_bit(INTT));
    add_step("tm0_max", OP_WR_TM0, 'hff, 0, CHK_NONE, 0);
    add_step("tm1_max", OP_WR_TM1, 'h0f, 0, CHK_NONE, 0);
    add_step("timer_slow", OP_STM, 0, 0, CHK_PEND, flag_bit(INTT));
    // Priority and acknowledge
    add_step("prio_int0", OP_INT0, 1, 1, CHK_PEND, flag_bit(INT0) | flag_bit(INTT));
    add_step("prio_int1", OP_INT1, 1, HOLD, CHK_PEND,
             flag_bit(INT0) | flag_bit(INTT) | flag_bit(INT1));
    add_step("prio_int1_rel", OP_INT1, 0, HOLD, CHK_PEND,
             flag_bit(INT0) | flag_bit(INTT) | flag_bit(INT1));
    add_step("mask_open", OP_WR_MK, 'hf0, 0, CHK_NONE, 0);
    add_step("enable_1", OP_EI, 0, 0, CHK_NONE, 0);
    add_step("fetch_1", OP_FETCH, 0, 0, CHK_VEC, int'(VEC_INT0));
    add_step("take_1", OP_TAKE, 0, 0, CHK_PEND, flag_bit(INTT) | flag_bit(INT1));
    add_step("int0_release", OP_INT0, 0, 1, CHK_PEND, flag_bit(INTT) | flag_bit(INT1));
    add_step("enable_2", OP_EI, 0, 0, CHK_NONE, 0);
    add_step("fetch_2", OP_FETCH, 0, 0, CHK_VEC, int'(VEC_INTT));
    add_step("take_2", OP_TAKE, 0, 0, CHK_PEND, flag_bit(INT1));
    add_step("enable_3", OP_EI, 0, 0, CHK_NONE, 0);
    add_step("fetch_3", OP_FETCH, 0, 0, CHK_VEC, int'(VEC_INT1));
    add_step("take_3", OP_TAKE, 0, 0, CHK_PEND, 0);
    // Disabled or masked requests
    add_step("int0_again", OP_INT0, 1, 1, CHK_PEND, flag_bit(INT0));
    add_step("enable_4", OP_EI, 0, 0, CHK_NONE, 0);
    add_step("disable", OP_DI, 0, 0, CHK_NONE, 0);
    add_step("fetch_disabled", OP_FETCH, 0, 0, CHK_REQ, 0);
    add_step("enable_5", OP_EI, 0, 0, CHK_NONE, 0);
    add_step("mask_int0", OP_WR_MK, 'hf1, 0, CHK_NONE, 0);
    add_step("fetch_masked", OP_FETCH, 0, 0, CHK_VEC, int'(VEC_NONE));
    add_step("unmask_int0", OP_WR_MK, 'hf0, 0, CHK_NONE, 0);
    add_step("fetch_unmasked", OP_FETCH, 0, 0, CHK_VEC, int'(VEC_INT0));
    add_step("int0_drop", OP_INT0, 0, 1, CHK_PEND, 0);
    add_step("fetch_empty", OP_FETCH, 0, 0, CHK_REQ, 0);
    // A take with no request leaves interrupts enabled
    add_step("take_no_req", OP_TAKE, 0, 0, CHK_REQ, 0);
    // Skip test
    add_step("skit_arm", OP_INT1, 1, HOLD, CHK_PEND, flag_bit(INT1));
    add_step("fetch_enabled", OP_FETCH, 0, 0, CHK_VEC, int'(VEC_INT1));
    add_step("skit_first", OP_SKIT, int'(INT1), 0, CHK_HIT, 1);
    add_step("skit_repeat", OP_SKIT, int'(INT1), 0, CHK_HIT, 0);
    add_step("skit_done", OP_INT1, 0, HOLD, CHK_PEND, 0);
  endtask

  function automatic int table_cycles();
    int total;
    total = 200;
    foreach (steps[i]) begin
      total += int'(steps[i].cycles) + 3;
      if (steps[i].op == OP_GLITCH) begin
        total += int'(steps[i].arg) * 3 * SAMPLE_DIV;
      end
      if (steps[i].op == OP_UF_PERIOD) begin
        total += 4 * int'(steps[i].exp) + 16;
      end
    end
    return total;
  endfunction

  //////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin : main
    int unsigned seed_ret;
    int0        = 1'b0;
    int1        = 1'b0;
    int2        = 1'b0;
    stm         = 1'b0;
    ei          = 1'b0;
    di          = 1'b0;
    fetch_start = 1'b0;
    irq_take    = 1'b0;
    skit        = 1'b0;
    skit_sel    = INT0;
    spr_wr      = '0;
    seed_ret    = $urandom(SEED);
    build_table();
    watchdog_cycles = table_cycles();
    wait (rst_n === 1'b1);
    foreach (steps[i]) begin
      run_step(names[i], steps[i]);
    end
    if (fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge CLK);
    fail_count++;
    $display("ERROR: watchdog expired after %0d cycles before the steps ended",
             watchdog_cycles);
    $display("Result: FAILED");
    $fatal(1, "Watchdog timeout");
  end

endmodule

/* dv/irq_timer_properties.sv */
//////////////////////////////////////////////////
// Concurrent checks on the interrupt controller
//////////////////////////////////////////////////

`timescale 1ns/1ps

module irq_timer_properties
  import irq_pkg::*;
(
  input logic       CLK,
  input logic       rst_n,
  input logic       irq_take,
  input logic       irq_req,
  input logic       ei,
  input logic       di,
  input logic       ie,
  input logic       int0,
  input logic       skit,
  input vector_t    irq_vector,
  input int_flags_t pending
);

  // Enable flag holds when a take finds no request
  a_take_keeps_enable: assert property (
    @(posedge CLK) disable iff (!rst_n)
      (irq_take && !irq_req && !ei && !di) |=> (ie == $past(ie))
  ) else $error("irq_take without irq_req changed the enable flag");

  a_idle_vector: assert property (
    @(posedge CLK) disable iff (!rst_n)
      !irq_req |-> (irq_vector == VEC_NONE)
  ) else $error("irq_vector is not the idle vector while irq_req is low");

  // Only the acknowledged flag may drop on a take
  a_single_clear: assert property (
    @(posedge CLK) disable iff (!rst_n)
      (irq_take && irq_req && !skit && (int0 || !pending[INT0]))
        |=> ($countones($past(pending) & ~pending) <= 1)
  ) else $error("irq_take cleared more than one pending flag");

endmodule

bind int_controller irq_timer_properties u_props (
  .CLK        (CLK),
  .rst_n      (rst_n),
  .irq_take   (irq_take),
  .irq_req    (irq_req),
  .ei         (ei),
  .di         (di),
  .ie         (ie),
  .int0       (int0),
  .skit       (skit),
  .irq_vector (irq_vector),
  .pending    (pending)
);

/* dv/tb_clock_gen.sv */
//////////////////////////////////////////////////
// Testbench clock and synchronous reset source
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic CLK,
  output logic rst_n
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // Reset held low over the first few rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst_n <= 1'b1;
  end

endmodule

/* logic/irq_timer_top.sv */
//////////////////////////////////////////////////
// Interrupt and timer subsystem top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module irq_timer_top
  import irq_pkg::*;
#(
  parameter int SAMPLE_DIV    = 12,
  parameter int PRESCALE_BITS = 3
) (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       int0,
  input  logic       int1,
  input  logic       int2,
  input  logic       stm,
  input  logic       ei,
  input  logic       di,
  input  logic       fetch_start,
  input  logic       irq_take,
  input  logic       skit,
  input  int_idx_e   skit_sel,
  input  spr_wr_s    spr_wr,
  output int_flags_t pending,
  output logic       irq_req,
  output vector_t    irq_vector,
  output logic       skit_hit,
  output logic       timer_uf
);

  ext_req_s ext_req;
  logic     mk5;

  // Edge filters for INT1 and INT2
  int_sampler #(
    .SAMPLE_DIV (SAMPLE_DIV)
  ) u_sampler (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .int1    (int1),
    .int2    (int2),
    .mk5     (mk5),
    .ext_req (ext_req)
  );

  interval_timer #(
    .PRESCALE_BITS (PRESCALE_BITS)
  ) u_timer (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .stm      (stm),
    .spr_wr   (spr_wr),
    .timer_uf (timer_uf)
  );

  // Combines the sampler and timer requests
  int_controller u_ctrl (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .int0        (int0),
    .ext_req     (ext_req),
    .timer_uf    (timer_uf),
    .ei          (ei),
    .di          (di),
    .fetch_start (fetch_start),
    .irq_take    (irq_take),
    .skit        (skit),
    .skit_sel    (skit_sel),
    .spr_wr      (spr_wr),
    .mk5         (mk5),
    .pending     (pending),
    .irq_req     (irq_req),
    .irq_vector  (irq_vector),
    .skit_hit    (skit_hit)
  );

endmodule

/* logic/int_controller.sv */
//////////////////////////////////////////////////
// Interrupt controller: pending flags, mask and
// enable, fetch latch, priority vector, skip test
//////////////////////////////////////////////////

`timescale 1ns/1ps

module int_controller
  import irq_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       int0,
  input  ext_req_s   ext_req,
  input  logic       timer_uf,
  input  logic       ei,
  input  logic       di,
  input  logic       fetch_start,
  input  logic       irq_take,
  input  logic       skit,
  input  int_idx_e   skit_sel,
  input  spr_wr_s    spr_wr,
  output logic       mk5,
  output int_flags_t pending,
  output logic       irq_req,
  output vector_t    irq_vector,
  output logic       skit_hit
);

  spr_data_t  mk;
  logic       ie;
  int_flags_t pend;
  int_flags_t pend_set;
  int_flags_t pend_clr;
  int_flags_t unmasked;
  int_flags_t latched;
  int_flags_t ack;
  int_flags_t skit_mask;
  logic       taken;

  //////////////////////////////////////////////////
  // Mask register and enable flag

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mk <= MK_RESET;
    end else if (spr_wr.en && (spr_wr.sel == SPR_MK)) begin
      mk <= spr_wr.data;
    end
  end

  assign mk5 = mk[5];

  // Taking the vector also disables further interrupts
  assign taken = irq_take && irq_req;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ie <= 1'b0;
    end else if (taken || di) begin
      ie <= 1'b0;
    end else if (ei) begin
      ie <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Pending flags

  always_comb begin
    pend_set       = '0;
    pend_set[INT0] = int0 && !pend[INT0];
    pend_set[INTT] = timer_uf;
    pend_set[INT1] = ext_req.int1;
    pend_set[INT2] = ext_req.int2;
  end

  assign skit_mask = skit ? (int_flags_t'(1) << skit_sel) : '0;

  always_comb begin
    pend_clr = '0;
    // INT0 follows the level of its line
    pend_clr[INT0] = !int0;
    if (taken) begin
      pend_clr = pend_clr | ack;
    end
    pend_clr = pend_clr | skit_mask;
  end

  // A set wins over a clear in the same cycle
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~pend_clr) | pend_set;
    end
  end

  assign pending  = pend;
  assign skit_hit = |(pend & skit_mask);

  //////////////////////////////////////////////////
  // Fetch latch and priority encoder

  always_comb begin
    unmasked       = '0;
    unmasked[INT0] = ie && !mk[0];
    unmasked[INTT] = ie && !mk[1];
    unmasked[INT1] = ie && !mk[2];
    unmasked[INT2] = ie && !mk[3];
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      latched <= '0;
    end else if (fetch_start) begin
      latched <= pend & unmasked;
    end
  end

  assign irq_req = |latched;

  // Lowest set bit has the highest priority
  assign ack = latched & (~latched + 1'b1);

  always_comb begin
    case (1'b1)
      ack[INT0]: irq_vector = VEC_INT0;
      ack[INTT]: irq_vector = VEC_INTT;
      ack[INT1]: irq_vector = VEC_INT1;
      ack[INT2]: irq_vector = VEC_INT2;
      default:   irq_vector = VEC_NONE;
    endcase
  end

endmodule

/* logic/interval_timer.sv */
//////////////////////////////////////////////////
// Interval timer: TM0/TM1 reload register and a
// prescaled 12-bit down counter with underflow
//////////////////////////////////////////////////

`timescale 1ns/1ps

module interval_timer
  import irq_pkg::*;
#(
  parameter int PRESCALE_BITS = 3
) (
  input  logic    CLK,
  input  logic    rst_n,
  input  logic    stm,
  input  spr_wr_s spr_wr,
  output logic    timer_uf
);

  localparam int CNT_W = TM_W + PRESCALE_BITS;

  typedef logic [CNT_W-1:0] timer_cnt_t;

  tm_count_t  tm;
  timer_cnt_t count;
  timer_cnt_t reload_val;
  logic       wr_tm0;
  logic       wr_tm1;

  //////////////////////////////////////////////////
  // Reload register

  assign wr_tm0 = spr_wr.en && (spr_wr.sel == SPR_TM0);
  assign wr_tm1 = spr_wr.en && (spr_wr.sel == SPR_TM1);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tm <= '1;
    end else begin
      if (wr_tm0) begin
        tm[7:0] <= spr_wr.data;
      end
      // Only the low nibble exists in TM1
      if (wr_tm1) begin
        tm[11:8] <= spr_wr.data[3:0];
      end
    end
  end

  //////////////////////////////////////////////////
  // Prescaled down counter

  // Prescaler restarts from all ones on every reload
  assign reload_val = {tm, {PRESCALE_BITS{1'b1}}};

  // Underflow is the cycle spent at zero
  assign timer_uf = (count == '0);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      count <= '1;
    end else if (timer_uf || stm) begin
      count <= reload_val;
    end else begin
      count <= count - 1'b1;
    end
  end

endmodule

/* logic/int_sampler.sv */
//////////////////////////////////////////////////
// External interrupt sampler: divided sample tick
// and edge filters for the INT1 and INT2 lines
//////////////////////////////////////////////////

`timescale 1ns/1ps

module int_sampler
  import irq_pkg::*;
#(
  parameter int SAMPLE_DIV = 12
) (
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     int1,
  input  logic     int2,
  input  logic     mk5,
  output ext_req_s ext_req
);

  localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

  typedef logic [DIV_W-1:0] div_cnt_t;

  localparam div_cnt_t DIV_LAST = div_cnt_t'(SAMPLE_DIV - 1);

  div_cnt_t   div_cnt;
  logic       tick;
  logic [3:0] hist1;
  logic [3:0] hist2;
  logic       int2_pol;

  //////////////////////////////////////////////////
  // Sample clock divider

  assign tick = (div_cnt == DIV_LAST);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Sample histories

  // MK bit 5 clear inverts the INT2 line
  assign int2_pol = int2 ^ ~mk5;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      hist1 <= '0;
      hist2 <= '0;
    end else if (tick) begin
      hist1 <= {hist1[2:0], int1};
      hist2 <= {hist2[2:0], int2_pol};
    end
  end

  // One low sample followed by three high ones, oldest in bit 3
  assign ext_req.int1 = tick && (hist1 == 4'b0111);
  assign ext_req.int2 = tick && (hist2 == 4'b0111);

endmodule

/* logic/irq_pkg.sv */
//////////////////////////////////////////////////
// Interrupt and timer subsystem shared types,
// register select codes and vector addresses
//////////////////////////////////////////////////

package irq_pkg;

  // Widths with a meaning of their own
  localparam int SPR_W    = 8;
  localparam int TM_W     = 12;
  localparam int NUM_INTS = 5;
  localparam int VEC_W    = 8;

  typedef logic [SPR_W-1:0]    spr_data_t;
  typedef logic [TM_W-1:0]     tm_count_t;
  typedef logic [NUM_INTS-1:0] int_flags_t;
  typedef logic [VEC_W-1:0]    vector_t;

  // Flag bit positions, highest priority first
  typedef enum logic [2:0] {
    INT0 = 3'd0,
    INTT = 3'd1,
    INT1 = 3'd2,
    INT2 = 3'd3,
    INTS = 3'd4   // Reserved, never set
  } int_idx_e;

  // Special register select on the write bus
  typedef enum logic [1:0] {
    SPR_MK  = 2'd0,
    SPR_TM0 = 2'd1,
    SPR_TM1 = 2'd2
  } spr_sel_e;

  //////////////////////////////////////////////////
  // Bundles

  typedef struct packed {
    logic      en;
    spr_sel_e  sel;
    spr_data_t data;
  } spr_wr_s;

  // Filtered edge requests, one cycle each
  typedef struct packed {
    logic int1;
    logic int2;
  } ext_req_s;

  //////////////////////////////////////////////////
  // Vector addresses

  localparam vector_t VEC_INT0 = 8'h04;
  localparam vector_t VEC_INTT = 8'h08;
  localparam vector_t VEC_INT1 = 8'h10;
  localparam vector_t VEC_INT2 = 8'h20;
  // Old software interrupt vector, now means no request
  localparam vector_t VEC_NONE = 8'h60;

  // All sources masked out of reset
  localparam spr_data_t MK_RESET = 8'hff;

endpackage
